// File: cdc_reg_bridge.f
+incdir+include
src/cdc_reg_bridge_pkg.sv
src/bit_synchronizer.sv
src/read_requester.sv
src/read_responder.sv
src/status_reg_bank.sv
src/cdc_reg_bridge_top.sv
dv/cdc_reg_bridge_tb.sv

// File: dv/cdc_reg_bridge_tb.sv
`timescale 1ns/100ps

module cdc_reg_bridge_tb;

import cdc_reg_bridge_pkg::*;

// ****************************************
// Table layout
// ****************************************

localparam logic [1:0] KIND_WRITE       = 2'd0;
localparam logic [1:0] KIND_READ        = 2'd1;
localparam logic [1:0] KIND_STALL_READ  = 2'd2;
localparam logic [1:0] KIND_DOUBLE_READ = 2'd3;

// One stimulus row
// Data is the write value, or the value written to addr^1 during a stall
typedef struct packed
{
	logic [1:0] kind;
	reg_addr_t  addr;
	reg_data_t  data;
	logic [7:0] stall;
} test_row_t;

// ****************************************
// DUT signals
// ****************************************

logic      rvx_port_02;
logic      rvx_port_01;
logic      req_clk;
logic      start;
reg_addr_t addr;
logic      busy;
logic      done;
reg_data_t rd_data;
logic      wr_en;
reg_addr_t wr_addr;
reg_data_t wr_data;

// Reference copy of the register bank
reg_data_t model [16];

test_row_t rows [$];
int        error_count;
int        check_count;
logic      timed_out;
integer    seed;
time       done_time;
time       stall_end_time;
reg_data_t stall_got;
logic      stall_ok;

cdc_reg_bridge_top dut0
(
	.rvx_port_02 (rvx_port_02),
	.rvx_port_01 (rvx_port_01),
	.req_clk     (req_clk),
	.start       (start),
	.addr        (addr),
	.busy        (busy),
	.done        (done),
	.rd_data     (rd_data),
	.wr_en       (wr_en),
	.wr_addr     (wr_addr),
	.wr_data     (wr_data)
);

// Register clock, 8 ns
initial
begin
	rvx_port_02 = 1'b0;
	forever #4 rvx_port_02 = ~rvx_port_02;
end

// Requester clock, 14 ns, unrelated to the register clock
initial
begin
	req_clk = 1'b0;
	forever #7 req_clk = ~req_clk;
end

// ****************************************
// Helpers
// ****************************************

task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	check_count++;
	if (got !== exp)
	begin
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		error_count++;
	end
endtask

function automatic test_row_t make_row(input logic [1:0] kind, input reg_addr_t a,
	input reg_data_t d, input logic [7:0] stall);
	test_row_t r;
	r.kind  = kind;
	r.addr  = a;
	r.data  = d;
	r.stall = stall;
	return r;
endfunction

// Single cycle write on the local port
task local_write(input reg_addr_t a, input reg_data_t d);
	@(negedge rvx_port_02);
	wr_en   = 1'b1;
	wr_addr = a;
	wr_data = d;
	@(negedge rvx_port_02);
	wr_en   = 1'b0;
	model[a] = d;
endtask

// Remote read, optionally with a second start while busy
task run_read(input reg_addr_t a, input logic second_start, input reg_addr_t a2,
	output reg_data_t data, output logic ok);
	int   cycles;
	int   extra_dones;
	logic seen;
	ok     = 1'b1;
	seen   = 1'b0;
	cycles = 0;
	data   = '0;
	@(negedge req_clk);
	start = 1'b1;
	addr  = a;
	@(negedge req_clk);
	if (second_start)
	begin
		// Requester is busy by now, this start must be ignored
		addr = a2;
		@(negedge req_clk);
	end
	start = 1'b0;
	// Outputs change on the rising edge, sampled here on the falling edge
	while (!seen && cycles < 500)
	begin
		if (done)
			seen = 1'b1;
		else
		begin
			check_value("busy", busy, 1'b1);
			@(negedge req_clk);
			cycles++;
		end
	end
	if (!seen)
	begin
		$display("Timeout: no done within 500 req_clk cycles for read of address 0x%0h", a);
		timed_out = 1'b1;
		ok        = 1'b0;
	end
	else
	begin
		done_time = $time;
		data      = rd_data;
		check_value("busy", busy, 1'b0);
		// done is one cycle wide and data stays held
		@(negedge req_clk);
		check_value("done", done, 1'b0);
		check_value("rd_data", rd_data, model[a]);
		if (second_start)
		begin
			extra_dones = 0;
			repeat (40)
			begin
				@(negedge req_clk);
				if (done)
					extra_dones++;
			end
			check_value("extra_done_count", extra_dones, 0);
		end
	end
endtask

// Read while wr_en is held on a neighbouring address
task stall_read(input reg_addr_t a, input reg_data_t d, input int len);
	fork
		begin
			@(negedge rvx_port_02);
			wr_en   = 1'b1;
			wr_addr = a ^ 4'h1;
			wr_data = d;
			repeat (len) @(negedge rvx_port_02);
			wr_en          = 1'b0;
			stall_end_time = $time;
		end
		begin
			// Let the stall begin before the request reaches the bank
			repeat (2) @(negedge rvx_port_02);
			run_read(a, 1'b0, '0, stall_got, stall_ok);
		end
	join
	model[a ^ 4'h1] = d;
	if (stall_ok)
	begin
		check_value("rd_data", stall_got, model[a]);
		check_value("done_after_stall", done_time > stall_end_time, 1'b1);
	end
endtask

// ****************************************
// Stimulus table
// ****************************************

task build_table();
	reg_data_t rnd;
	// Reset values
	rows.push_back(make_row(KIND_READ, 4'h0, 8'h00, 8'd0));
	rows.push_back(make_row(KIND_READ, 4'h5, 8'h00, 8'd0));
	rows.push_back(make_row(KIND_READ, 4'hf, 8'h00, 8'd0));
	// Write then read back
	rows.push_back(make_row(KIND_WRITE, 4'h3, 8'ha5, 8'd0));
	rows.push_back(make_row(KIND_READ, 4'h3, 8'h00, 8'd0));
	// Back pressure from a held local write
	rows.push_back(make_row(KIND_WRITE, 4'h7, 8'h3c, 8'd0));
	rows.push_back(make_row(KIND_STALL_READ, 4'h7, 8'h99, 8'd40));
	rows.push_back(make_row(KIND_READ, 4'h6, 8'h00, 8'd0));
	// Second start goes to the inverted address
	rows.push_back(make_row(KIND_WRITE, 4'h9, 8'h5a, 8'd0));
	rows.push_back(make_row(KIND_WRITE, 4'h6, 8'hc3, 8'd0));
	rows.push_back(make_row(KIND_DOUBLE_READ, 4'h9, 8'h00, 8'd0));
	// Random fill of every register, then read all
	for (int i = 0; i < 16; i++)
	begin
		rnd = $random(seed);
		rows.push_back(make_row(KIND_WRITE, i[3:0], rnd, 8'd0));
	end
	for (int i = 0; i < 16; i++)
	begin
		rows.push_back(make_row(KIND_READ, i[3:0], 8'h00, 8'd0));
	end
endtask

// ****************************************
// Main sequence
// ****************************************

initial
begin
	test_row_t row;
	int        errs_before;
	int        rows_run;
	string     kind_name;
	reg_data_t got;
	logic      ok;
	rvx_port_01 = 1'b0;
	start       = 1'b0;
	addr        = '0;
	wr_en       = 1'b0;
	wr_addr     = '0;
	wr_data     = '0;
	error_count = 0;
	check_count = 0;
	rows_run    = 0;
	timed_out   = 1'b0;
	seed        = 14639;
	for (int i = 0; i < 16; i++)
	begin
		model[i] = '0;
	end
	build_table();
	repeat (10) @(negedge rvx_port_02);
	rvx_port_01 = 1'b1;
	@(negedge req_clk);
	check_value("busy", busy, 1'b0);
	check_value("done", done, 1'b0);
	for (int i = 0; i < rows.size(); i++)
	begin
		row         = rows[i];
		errs_before = error_count;
		case (row.kind)
			KIND_WRITE:
			begin
				kind_name = "write";
				local_write(row.addr, row.data);
			end
			KIND_READ:
			begin
				kind_name = "read";
				run_read(row.addr, 1'b0, '0, got, ok);
				if (ok)
					check_value("rd_data", got, model[row.addr]);
			end
			KIND_STALL_READ:
			begin
				kind_name = "stalled read";
				stall_read(row.addr, row.data, row.stall);
			end
			default:
			begin
				kind_name = "double start read";
				run_read(row.addr, 1'b1, ~row.addr, got, ok);
				if (ok)
					check_value("rd_data", got, model[row.addr]);
			end
		endcase
		rows_run++;
		$display("Row %0d: %s addr 0x%0h data 0x%0h %s", i, kind_name, row.addr, row.data,
			(error_count == errs_before && !timed_out) ? "ok" : "error");
		if (timed_out)
			break;
	end
	$display("Finished %0d rows, %0d checks, %0d errors", rows_run, check_count, error_count);
	if (error_count == 0 && !timed_out)
		$display("All checks passed");
	else
		$display("Checks failed");
	$finish;
end

endmodule

// File: include/cdc_reg_bridge_settings.svh
`ifndef CDC_REG_BRIDGE_SETTINGS_SVH
`define CDC_REG_BRIDGE_SETTINGS_SVH

// ****************************************
// Register bank geometry
// ****************************************

// Address bits select one of sixteen registers
`define BRG_ADDR_W 4

// Width of one register
`define BRG_DATA_W 8

// ****************************************
// Clock crossing
// ****************************************

// Flops per synchronizer chain
`define BRG_SYNC_STAGES 2

`endif

// File: src/bit_synchronizer.sv
`timescale 1ns/100ps
`include "cdc_reg_bridge_settings.svh"

module bit_synchronizer
#(
	parameter int WIDTH = 1
)
(
	input  logic             rvx_port_02,
	input  logic             rvx_port_01,
	input  logic [WIDTH-1:0] async_in,
	output logic [WIDTH-1:0] sync_out
);

// Chain length comes from the shared settings
localparam int STAGES = `BRG_SYNC_STAGES;

// Stage 0 is the metastable capture flop
logic [WIDTH-1:0] stage_q [STAGES];

always_ff @(posedge rvx_port_02 or negedge rvx_port_01)
begin
	if (!rvx_port_01)
	begin
		// Whole chain starts at zero
		for (int i = 0; i < STAGES; i++)
		begin
			stage_q[i] <= '0;
		end
	end
	else
	begin
		// Sample the foreign bundle
		stage_q[0] <= async_in;
		// Shift toward the output
		for (int i = 1; i < STAGES; i++)
		begin
			stage_q[i] <= stage_q[i-1];
		end
	end
end

// Last stage is safe to use in this domain
assign sync_out = stage_q[STAGES-1];

endmodule

// File: src/cdc_reg_bridge_pkg.sv
`include "cdc_reg_bridge_settings.svh"

package cdc_reg_bridge_pkg;

// ****************************************
// Basic vectors
// ****************************************

// Register index inside the bank
typedef logic [`BRG_ADDR_W-1:0] reg_addr_t;

// Register content
typedef logic [`BRG_DATA_W-1:0] reg_data_t;

// ****************************************
// Crossing bundles
// ****************************************

// Request bundle toward the register domain
// Toggle sits in the MSB
typedef struct packed
{
	logic      toggle;
	reg_addr_t addr;
} brg_req_t;

// Response bundle toward the requester domain
typedef struct packed
{
	logic      toggle;
	reg_data_t data;
} brg_rsp_t;

// ****************************************
// Requester FSM
// ****************************************

typedef enum logic
{
	REQ_IDLE,
	REQ_WAIT
} req_state_t;

endpackage

// File: src/cdc_reg_bridge_top.sv
`timescale 1ns/100ps

module cdc_reg_bridge_top
(
	input  logic                          rvx_port_02,
	input  logic                          rvx_port_01,
	input  logic                          req_clk,
	input  logic                          start,
	input  cdc_reg_bridge_pkg::reg_addr_t addr,
	output logic                          busy,
	output logic                          done,
	output cdc_reg_bridge_pkg::reg_data_t rd_data,
	input  logic                          wr_en,
	input  cdc_reg_bridge_pkg::reg_addr_t wr_addr,
	input  cdc_reg_bridge_pkg::reg_data_t wr_data
);

import cdc_reg_bridge_pkg::*;

// ****************************************
// Crossing bundles
// ****************************************

// Request in both domains
brg_req_t req_out;
brg_req_t req_sync;

// Response in both domains
brg_rsp_t rsp_out;
brg_rsp_t rsp_sync;

// Responder and bank handshake
logic      pending;
logic      serve;
reg_addr_t rd_addr;
reg_data_t serve_data;

// ****************************************
// Requester domain
// ****************************************

read_requester u_requester
(
	.req_clk     (req_clk),
	.rvx_port_01 (rvx_port_01),
	.start       (start),
	.addr        (addr),
	.busy        (busy),
	.done        (done),
	.rd_data     (rd_data),
	.req_out     (req_out),
	.rsp_sync    (rsp_sync)
);

// Response into req_clk
bit_synchronizer
#(
	.WIDTH ($bits(brg_rsp_t))
)
u_rsp_sync
(
	.rvx_port_02 (req_clk),
	.rvx_port_01 (rvx_port_01),
	.async_in    (rsp_out),
	.sync_out    (rsp_sync)
);

// ****************************************
// Register domain
// ****************************************

// Request into rvx_port_02
bit_synchronizer
#(
	.WIDTH ($bits(brg_req_t))
)
u_req_sync
(
	.rvx_port_02 (rvx_port_02),
	.rvx_port_01 (rvx_port_01),
	.async_in    (req_out),
	.sync_out    (req_sync)
);

read_responder u_responder
(
	.rvx_port_02 (rvx_port_02),
	.rvx_port_01 (rvx_port_01),
	.req_sync    (req_sync),
	.serve       (serve),
	.serve_data  (serve_data),
	.pending     (pending),
	.rd_addr     (rd_addr),
	.rsp_out     (rsp_out)
);

status_reg_bank u_bank
(
	.rvx_port_02 (rvx_port_02),
	.rvx_port_01 (rvx_port_01),
	.wr_en       (wr_en),
	.wr_addr     (wr_addr),
	.wr_data     (wr_data),
	.pending     (pending),
	.rd_addr     (rd_addr),
	.serve       (serve),
	.serve_data  (serve_data)
);

endmodule

// File: src/read_requester.sv
`timescale 1ns/100ps

module read_requester
(
	input  logic                          req_clk,
	input  logic                          rvx_port_01,
	input  logic                          start,
	input  cdc_reg_bridge_pkg::reg_addr_t addr,
	output logic                          busy,
	output logic                          done,
	output cdc_reg_bridge_pkg::reg_data_t rd_data,
	output cdc_reg_bridge_pkg::brg_req_t  req_out,
	input  cdc_reg_bridge_pkg::brg_rsp_t  rsp_sync
);

import cdc_reg_bridge_pkg::*;

// ****************************************
// State and request bundle
// ****************************************

req_state_t state_q;

// Flips once per launched request
logic req_toggle_q;

// Address held while the request is in flight
reg_addr_t addr_q;

// Returning toggle caught up with ours
logic rsp_match;

assign rsp_match = (rsp_sync.toggle == req_toggle_q);

// ****************************************
// FSM
// ****************************************

always_ff @(posedge req_clk or negedge rvx_port_01)
begin
	if (!rvx_port_01)
	begin
		state_q      <= REQ_IDLE;
		req_toggle_q <= 1'b0;
		addr_q       <= '0;
		done         <= 1'b0;
	end
	else
	begin
		// done is a single cycle pulse
		done <= 1'b0;
		case (state_q)
			REQ_IDLE:
			begin
				// Start only counts while idle
				if (start)
				begin
					addr_q       <= addr;
					req_toggle_q <= ~req_toggle_q;
					state_q      <= REQ_WAIT;
				end
			end
			REQ_WAIT:
			begin
				// Acknowledge toggle now equals ours
				if (rsp_match)
				begin
					done    <= 1'b1;
					state_q <= REQ_IDLE;
				end
			end
			default:
			begin
				state_q <= REQ_IDLE;
			end
		endcase
	end
end

// ****************************************
// Read data capture
// ****************************************

// Data word travels in the same bundle as the toggle
always_ff @(posedge req_clk or negedge rvx_port_01)
begin
	if (!rvx_port_01)
		rd_data <= '0;
	else if ((state_q == REQ_WAIT) && rsp_match)
		rd_data <= rsp_sync.data;
end

// Busy drops together with the done pulse
assign busy = (state_q == REQ_WAIT);

// Bundle sent across to the register domain
assign req_out.toggle = req_toggle_q;
assign req_out.addr   = addr_q;

endmodule

// File: src/read_responder.sv
`timescale 1ns/100ps

module read_responder
(
	input  logic                          rvx_port_02,
	input  logic                          rvx_port_01,
	input  cdc_reg_bridge_pkg::brg_req_t  req_sync,
	input  logic                          serve,
	input  cdc_reg_bridge_pkg::reg_data_t serve_data,
	output logic                          pending,
	output cdc_reg_bridge_pkg::reg_addr_t rd_addr,
	output cdc_reg_bridge_pkg::brg_rsp_t  rsp_out
);

import cdc_reg_bridge_pkg::*;

// ****************************************
// Acknowledge side of the toggle pair
// ****************************************

logic ack_toggle_q;

// Captured answer for the requester
reg_data_t data_q;

// Accept only while a request is open
logic ack_en;

// Open request while the two toggles differ
assign pending = (req_sync.toggle != ack_toggle_q);
assign ack_en  = pending & serve;

// Address comes straight from the synchronized bundle
assign rd_addr = req_sync.addr;

always_ff @(posedge rvx_port_02 or negedge rvx_port_01)
begin
	if (!rvx_port_01)
		ack_toggle_q <= 1'b0;
	else if (ack_en)
		// Closes the request one cycle after serve
		ack_toggle_q <= ~ack_toggle_q;
end

// Data changes on the same edge as the toggle
always_ff @(posedge rvx_port_02 or negedge rvx_port_01)
begin
	if (!rvx_port_01)
		data_q <= '0;
	else if (ack_en)
		data_q <= serve_data;
end

// Response bundle back to the requester domain
assign rsp_out.toggle = ack_toggle_q;
assign rsp_out.data   = data_q;

endmodule

// File: src/status_reg_bank.sv
`timescale 1ns/100ps
`include "cdc_reg_bridge_settings.svh"

module status_reg_bank
(
	input  logic                          rvx_port_02,
	input  logic                          rvx_port_01,
	input  logic                          wr_en,
	input  cdc_reg_bridge_pkg::reg_addr_t wr_addr,
	input  cdc_reg_bridge_pkg::reg_data_t wr_data,
	input  logic                          pending,
	input  cdc_reg_bridge_pkg::reg_addr_t rd_addr,
	output logic                          serve,
	output cdc_reg_bridge_pkg::reg_data_t serve_data
);

import cdc_reg_bridge_pkg::*;

// ****************************************
// Storage
// ****************************************

// One entry per address value
localparam int REG_COUNT = 2 ** `BRG_ADDR_W;

reg_data_t regs_q [REG_COUNT];

// ****************************************
// Local write port
// ****************************************

// Write lands on the edge where wr_en is high
always_ff @(posedge rvx_port_02 or negedge rvx_port_01)
begin
	if (!rvx_port_01)
	begin
		// All status registers read as zero after reset
		for (int i = 0; i < REG_COUNT; i++)
		begin
			regs_q[i] <= '0;
		end
	end
	else if (wr_en)
	begin
		regs_q[wr_addr] <= wr_data;
	end
end

// ****************************************
// Remote read arbitration
// ****************************************

// Local write wins the cycle
// A pending read waits while wr_en is held
assign serve = pending & ~wr_en;

// Addressed register as seen before any write this cycle
// Serve never coincides with a write so the value is current
assign serve_data = regs_q[rd_addr];

endmodule
